// File: Makefile
# Verilator build and run of the CPU slice testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run tb_cpu_slice, search $(LOG) for the pass line"
	@echo "  clean  remove the build folder and the log"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module tb_cpu_slice -f build.f --Mdir obj_dir -o tb_cpu_slice
	./obj_dir/tb_cpu_slice > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^No errors$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/isa_model.sv
module isa_model
	import isa_pkg::*, pipe_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	// Architectural state, r0 is never written
	word_t       regs [NUM_REGS];
	word_t       mem [word_t];
	logic [36:0] wb_q [$];

	initial begin
		for (int i = 0; i < NUM_REGS; i++) begin
			regs[i] = '0;
		end
	end

	// Content of a data word that was never stored
	function automatic word_t fill_word(word_t addr);
		return {addr[15:0], addr[31:16]} ^ 32'h3c5a_96e1;
	endfunction

	function automatic int pending_wb();
		return wb_q.size();
	endfunction

	// Oldest expected register write
	task automatic pop_wb(output logic found, output reg_idx_t r, output word_t d);
		logic [36:0] e;
		found = (wb_q.size() > 0);
		e = '0;
		if (found) begin
			e = wb_q.pop_front();
		end
		r = e[36:32];
		d = e[31:0];
	endtask

	// Runs one instruction and returns what execute must show for it
	task automatic execute(
		input  word_t w,
		input  word_t pc,
		output logic  rd_en,
		output logic  wr_en,
		output word_t addr,
		output word_t wdata,
		output logic  taken,
		output word_t target
	);
		logic [5:0] op;
		reg_idx_t   rd;
		word_t      a;
		word_t      b;
		word_t      rdv;
		word_t      imm_s;
		word_t      res;
		logic       writes;
		op = w[31:26];
		rd = w[25:21];
		a = regs[w[20:16]];
		b = regs[w[15:11]];
		rdv = regs[rd];
		imm_s = {{16{w[15]}}, w[15:0]};
		addr = a + imm_s;
		wdata = rdv;
		target = pc + (imm_s << 2);
		rd_en = 1'b0;
		wr_en = 1'b0;
		taken = 1'b0;
		res = '0;
		writes = op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_LUI,
			OP_LW};
		if (op[5:2] == BR_GROUP) begin
			case (op[1:0])
				BR_EQ:   taken = (a == rdv);
				BR_NE:   taken = (a != rdv);
				BR_LT:   taken = ($signed(a) < $signed(rdv));
				default: taken = 1'b1;
			endcase
		end else begin
			case (op)
				OP_ADD:  res = a + b;
				OP_SUB:  res = a - b;
				OP_AND:  res = a & b;
				OP_OR:   res = a | b;
				OP_XOR:  res = a ^ b;
				OP_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				OP_ADDI: res = addr;
				OP_LUI:  res = {w[15:0], 16'h0000};
				OP_LW: begin
					rd_en = 1'b1;
					res = mem.exists(addr) ? mem[addr] : fill_word(addr);
				end
				OP_SW: begin
					wr_en = 1'b1;
					mem[addr] = rdv;
				end
				default: ;
			endcase
		end
		if (writes) begin
			wb_q.push_back({rd, res});
			if (rd != '0) begin
				regs[rd] = res;
			end
		end
	endtask

endmodule

// File: bench/tb_cpu_slice.sv
module tb_cpu_slice
	import isa_pkg::*, pipe_ctrl_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_INSTR   = 400;
	localparam int NUM_DRAIN   = 4;
	localparam int CLK_PERIOD  = 40;
	localparam int RESET_CYC   = 8;
	localparam int WATCHDOG_NS = 3 * NUM_INSTR * CLK_PERIOD + RESET_CYC * CLK_PERIOD;

	logic     clk;
	logic     rst_n;
	word_t    instr;
	word_t    pc;
	word_t    mem_rdata;
	logic     stall;
	logic     branch_taken;
	word_t    branch_target;
	logic     mem_read;
	logic     mem_write;
	word_t    mem_addr;
	word_t    mem_wdata;
	logic     wb_en;
	reg_idx_t wb_reg;
	word_t    wb_data;

	integer   seed;
	int       mismatch_count;
	int       other_count;
	word_t    data_mem [word_t];

	// What the instruction now in ID/EX should show
	logic     exp_rd;
	logic     exp_wr;
	logic     exp_taken;
	word_t    exp_addr;
	word_t    exp_wdata;
	word_t    exp_target;

	cpu_slice_top cpu_slice_top_i (
		.clk(clk), .rst_n(rst_n), .instr(instr), .pc(pc), .mem_rdata(mem_rdata),
		.stall(stall), .branch_taken(branch_taken), .branch_target(branch_target),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data)
	);

	isa_model model_i ();

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before all instructions were run");
		$display("Errors found");
		$finish;
	end

	// Registers r0..r7 only so that dependences are frequent
	function automatic word_t random_instr();
		logic [31:0] r;
		logic [31:0] f;
		logic [5:0]  op;
		logic [15:0] imm;
		r = $random(seed);
		f = $random(seed);
		imm = f[15:0];
		case (r[3:0])
			4'd0:        op = OP_NOP;
			4'd1:        op = OP_ADD;
			4'd2:        op = OP_SUB;
			4'd3:        op = OP_AND;
			4'd4:        op = OP_OR;
			4'd5:        op = OP_XOR;
			4'd6:        op = OP_SLT;
			4'd7:        op = OP_LUI;
			4'd8, 4'd9:  op = OP_LW;
			4'd10:       op = OP_SW;
			4'd11, 4'd12: op = {BR_GROUP, r[5:4]};
			default:     op = OP_ADDI;
		endcase
		if (op == OP_LW || op == OP_SW) begin
			// Small word offsets so that loads meet earlier stores
			imm = f[15:0] & 16'h003c;
		end else if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT}) begin
			imm = {2'b00, f[13:0]};
		end
		return {op, 2'b00, r[8:6], 2'b00, r[11:9], imm};
	endfunction

	// Does the instruction really read register r
	function automatic logic reads_reg(word_t w, reg_idx_t r);
		logic [5:0] op;
		logic       hit;
		op = w[31:26];
		hit = 1'b0;
		if (op[5:2] == BR_GROUP || op == OP_SW) begin
			hit = (w[20:16] == r) || (w[25:21] == r);
		end else if (op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT}) begin
			hit = (w[20:16] == r) || (w[15:11] == r);
		end else if (op == OP_ADDI || op == OP_LW) begin
			hit = (w[20:16] == r);
		end
		return hit;
	endfunction

	// Writers that can queue behind a pending load write-back
	function automatic logic is_alu_write(word_t w);
		logic [5:0] op;
		op = w[31:26];
		return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_ADDI, OP_LUI};
	endfunction

	task automatic expect_idle();
		assert (!stall && !branch_taken && !mem_read && !mem_write && !wb_en) else begin
			mismatch_count++;
			$display("Mismatch at %0t: control outputs active during reset", $time);
		end
	endtask

	task automatic compare_execute();
		assert (mem_read == exp_rd && mem_write == exp_wr && branch_taken == exp_taken)
		else begin
			mismatch_count++;
			$display("Mismatch at %0t: read/write/branch %b%b%b, expected %b%b%b", $time,
				mem_read, mem_write, branch_taken, exp_rd, exp_wr, exp_taken);
		end
		if (exp_rd || exp_wr) begin
			assert (mem_addr == exp_addr) else begin
				mismatch_count++;
				$display("Mismatch at %0t: mem_addr %h, expected %h", $time, mem_addr, exp_addr);
			end
		end
		if (exp_wr) begin
			assert (mem_wdata == exp_wdata) else begin
				mismatch_count++;
				$display("Mismatch at %0t: mem_wdata %h, expected %h", $time, mem_wdata,
					exp_wdata);
			end
		end
		if (exp_taken) begin
			assert (branch_target == exp_target) else begin
				mismatch_count++;
				$display("Mismatch at %0t: branch_target %h, expected %h", $time,
					branch_target, exp_target);
			end
		end
	endtask

	task automatic match_writeback();
		logic     found;
		reg_idx_t e_reg;
		word_t    e_data;
		if (wb_en) begin
			model_i.pop_wb(found, e_reg, e_data);
			assert (found) else begin
				other_count++;
				$display("Write-back to r%0d at %0t that no instruction asked for", wb_reg,
					$time);
			end
			if (found) begin
				assert (wb_reg == e_reg && wb_data == e_data) else begin
					mismatch_count++;
					$display("Mismatch at %0t: write-back r%0d = %h, expected r%0d = %h",
						$time, wb_reg, wb_data, e_reg, e_data);
				end
			end
		end
	endtask

	initial begin
		word_t    cur_instr;
		word_t    cur_pc;
		word_t    next_pc;
		word_t    rdata;
		logic     hold;
		logic     need_stall;
		logic     ex_late;
		reg_idx_t late_dest;
		int       n_fetched;
		seed = 32'h5c71_e22b;
		mismatch_count = 0;
		other_count = 0;
		rst_n = 1'b0;
		instr = '0;
		pc = '0;
		mem_rdata = '0;
		exp_rd = 1'b0;
		exp_wr = 1'b0;
		exp_taken = 1'b0;
		exp_addr = '0;
		exp_wdata = '0;
		exp_target = '0;
		cur_instr = '0;
		cur_pc = '0;
		next_pc = 32'h0000_1000;
		rdata = '0;
		hold = 1'b0;
		ex_late = 1'b0;
		late_dest = '0;
		n_fetched = 0;

		for (int c = 1; c < RESET_CYC; c++) begin
			@(negedge clk);
			expect_idle();
		end

		// Fetch side holds on stall and redirects after a taken branch
		while (n_fetched < NUM_INSTR + NUM_DRAIN || hold) begin
			@(posedge clk);
			#2;
			rst_n = 1'b1;
			if (!hold) begin
				cur_pc = next_pc;
				if (n_fetched < NUM_INSTR) begin
					cur_instr = random_instr();
				end else begin
					cur_instr = '0;
				end
				next_pc = cur_pc + 32'd4;
				n_fetched++;
			end
			instr = cur_instr;
			pc = cur_pc;
			mem_rdata = rdata;

			@(negedge clk);
			compare_execute();
			match_writeback();
			need_stall = (late_dest != '0) && reads_reg(cur_instr, late_dest);
			assert (stall == need_stall) else begin
				mismatch_count++;
				$display("Mismatch at %0t: stall %b, expected %b with late write to r%0d",
					$time, stall, need_stall, late_dest);
			end

			if (mem_write) begin
				data_mem[mem_addr] = mem_wdata;
			end
			if (mem_read) begin
				rdata = data_mem.exists(mem_addr) ? data_mem[mem_addr]
					: model_i.fill_word(mem_addr);
			end

			hold = stall;
			late_dest = '0;
			if (stall || exp_taken) begin
				// Squashed or stalled slot leaves a bubble in ID/EX
				if (exp_taken && !stall) begin
					next_pc = exp_target;
				end
				exp_rd = 1'b0;
				exp_wr = 1'b0;
				exp_taken = 1'b0;
				ex_late = 1'b0;
			end else begin
				// A load writes one cycle late and so does an ALU op queued behind one
				if (cur_instr[31:26] == OP_LW) begin
					ex_late = 1'b1;
				end else begin
					ex_late = ex_late && is_alu_write(cur_instr);
				end
				if (ex_late) begin
					late_dest = cur_instr[25:21];
				end
				model_i.execute(cur_instr, cur_pc, exp_rd, exp_wr, exp_addr, exp_wdata,
					exp_taken, exp_target);
			end
		end

		assert (model_i.pending_wb() == 0) else begin
			other_count++;
			$display("%0d expected write-backs never appeared", model_i.pending_wb());
		end
		$display("Checks done with %0d mismatches and %0d other errors", mismatch_count,
			other_count);
		if (mismatch_count + other_count == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// File: build.f
common/isa_pkg.sv
common/pipe_ctrl_pkg.sv
decode/cpu_control.sv
decode/reg_file.sv
hw/hazard_detector.sv
hw/idex_reg.sv
hw/ex_stage.sv
hw/cpu_slice_top.sv
bench/isa_model.sv
bench/tb_cpu_slice.sv

// File: common/isa_pkg.sv
package isa_pkg;

	// Instruction word fields
	localparam int OPCODE_MSB = 31;
	localparam int OPCODE_LSB = 26;
	localparam int RD_MSB     = 25;
	localparam int RD_LSB     = 21;
	localparam int RS1_MSB    = 20;
	localparam int RS1_LSB    = 16;
	localparam int RS2_MSB    = 15;
	localparam int RS2_LSB    = 11;
	localparam int IMM_MSB    = 15;
	localparam int IMM_LSB    = 0;

	// Branches occupy four opcodes, the low two opcode bits carry br_cond_t
	localparam logic [3:0] BR_GROUP = 4'b1011;
	localparam int BR_COND_MSB = 27;
	localparam int BR_COND_LSB = 26;

	// R-type:  rd <= rs1 op rs2
	// ADDI:    rd <= rs1 + sext(imm16)
	// LUI:     rd <= {imm16, 16'h0}
	// LW:      rd <= mem[rs1 + sext(imm16)]
	// SW:      mem[rs1 + sext(imm16)] <= rd field register (rs2 slot overlaps imm16)
	// BR:      if (rs1 cond rd) pc <= pc + sext(imm16) * 4
	typedef enum logic [5:0] {
		OP_NOP  = 6'h00,
		OP_ADD  = 6'h01,
		OP_SUB  = 6'h02,
		OP_AND  = 6'h03,
		OP_OR   = 6'h04,
		OP_XOR  = 6'h05,
		OP_SLT  = 6'h06,
		OP_ADDI = 6'h08,
		OP_LUI  = 6'h09,
		OP_LW   = 6'h0a,
		OP_SW   = 6'h0b,
		OP_BR   = 6'h2c   // BR_GROUP with BR_EQ, the other three conditions follow
	} opcode_t;

	typedef enum logic [1:0] {
		BR_EQ     = 2'd0,
		BR_NE     = 2'd1,
		BR_LT     = 2'd2,   // signed compare
		BR_ALWAYS = 2'd3
	} br_cond_t;

endpackage

// File: common/pipe_ctrl_pkg.sv
package pipe_ctrl_pkg;

	localparam int WORD_W    = 32;
	localparam int REG_IDX_W = 5;
	localparam int NUM_REGS  = 32;

	typedef logic [WORD_W-1:0]    word_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Operation selected for the execute stage ALU
	typedef enum logic [2:0] {
		ALU_ADD    = 3'd0,
		ALU_SUB    = 3'd1,
		ALU_AND    = 3'd2,
		ALU_OR     = 3'd3,
		ALU_XOR    = 3'd4,
		ALU_SLT    = 3'd5,   // signed less than, result 0 or 1
		ALU_PASS_B = 3'd6
	} alu_op_t;

endpackage

// File: decode/cpu_control.sv
module cpu_control
	import isa_pkg::*, pipe_ctrl_pkg::*;
(
	input  opcode_t  opcode,
	output logic     reg_write,
	output logic     mem_read,
	output logic     mem_write,
	output logic     mem_to_reg,
	output logic     alu_src_imm,
	output logic     load_imm,
	output logic     branch,
	output br_cond_t br_cond,
	output alu_op_t  alu_op
);

	logic [5:0] op_bits;
	logic       is_branch;

	assign op_bits   = opcode;
	assign is_branch = (op_bits[5:2] == BR_GROUP);

	always_comb begin
		reg_write   = 1'b0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_to_reg  = 1'b0;
		alu_src_imm = 1'b0;
		load_imm    = 1'b0;
		branch      = 1'b0;
		br_cond     = BR_EQ;
		alu_op      = ALU_ADD;

		if (is_branch) begin
			branch  = 1'b1;
			br_cond = br_cond_t'(op_bits[1:0]);
			alu_op  = ALU_SUB;
		end else begin
			case (opcode)
				OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: begin
					reg_write = 1'b1;
					case (opcode)
						OP_SUB:  alu_op = ALU_SUB;
						OP_AND:  alu_op = ALU_AND;
						OP_OR:   alu_op = ALU_OR;
						OP_XOR:  alu_op = ALU_XOR;
						OP_SLT:  alu_op = ALU_SLT;
						default: alu_op = ALU_ADD;
					endcase
				end
				OP_ADDI: begin
					reg_write   = 1'b1;
					alu_src_imm = 1'b1;
				end
				OP_LUI: begin
					reg_write   = 1'b1;
					alu_src_imm = 1'b1;
					load_imm    = 1'b1;
					alu_op      = ALU_PASS_B;
				end
				OP_LW: begin
					reg_write   = 1'b1;
					mem_read    = 1'b1;
					mem_to_reg  = 1'b1;
					alu_src_imm = 1'b1;
				end
				OP_SW: begin
					mem_write   = 1'b1;
					alu_src_imm = 1'b1;
				end
				// NOP and undefined codes leave everything off
				default: ;
			endcase
		end
	end

	// Load and store share one address bus
	always_comb begin
		assert (!(mem_read && mem_write))
			else $error("cpu_control: read and write strobes decoded together");
	end

endmodule

// File: decode/reg_file.sv
module reg_file
	import pipe_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	input  logic     we,
	input  reg_idx_t wr_idx,
	input  word_t    wr_data,
	output word_t    rs1_data,
	output word_t    rs2_data
);

	word_t regs [NUM_REGS];

	// Same-cycle write is visible to decode, this replaces forwarding
	function automatic word_t read_port(reg_idx_t idx);
		word_t value;
		if (idx == '0) begin
			value = '0;
		end else if (we && (wr_idx == idx)) begin
			value = wr_data;
		end else begin
			value = regs[idx];
		end
		return value;
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (wr_idx != '0)) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign rs1_data = read_port(rs1_idx);
	assign rs2_data = read_port(rs2_idx);

endmodule

// File: hw/cpu_slice_top.sv
module cpu_slice_top
	import isa_pkg::*, pipe_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  word_t    instr,
	input  word_t    pc,
	input  word_t    mem_rdata,
	output logic     stall,
	output logic     branch_taken,
	output word_t    branch_target,
	output logic     mem_read,
	output logic     mem_write,
	output word_t    mem_addr,
	output word_t    mem_wdata,
	output logic     wb_en,
	output reg_idx_t wb_reg,
	output word_t    wb_data
);

	opcode_t     dec_opcode;
	reg_idx_t    dec_rd;
	reg_idx_t    dec_rs1;
	reg_idx_t    dec_rs2;
	reg_idx_t    rd2_idx;
	reg_idx_t    haz_rs1;
	logic [15:0] dec_imm;
	logic        uses_rs1;
	logic        uses_rs2;
	word_t       rs1_data;
	word_t       rs2_data;

	logic        ctl_reg_write;
	logic        ctl_mem_read;
	logic        ctl_mem_write;
	logic        ctl_mem_to_reg;
	logic        ctl_alu_src_imm;
	logic        ctl_load_imm;
	logic        ctl_branch;
	br_cond_t    ctl_br_cond;
	alu_op_t     ctl_alu_op;

	logic        data_hazard;
	logic        pc_hazard;
	logic        wb_deferred;

	logic        ex_reg_write;
	logic        ex_mem_read;
	logic        ex_mem_write;
	logic        ex_mem_to_reg;
	logic        ex_alu_src_imm;
	logic        ex_load_imm;
	logic        ex_branch;
	br_cond_t    ex_br_cond;
	alu_op_t     ex_alu_op;
	reg_idx_t    ex_dest;
	logic [15:0] ex_imm;
	word_t       ex_op_a;
	word_t       ex_op_b;
	word_t       ex_pc;
	word_t       ex_store_data;

	// Instruction fields
	assign dec_opcode = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);
	assign dec_rd     = instr[RD_MSB:RD_LSB];
	assign dec_rs1    = instr[RS1_MSB:RS1_LSB];
	assign dec_rs2    = instr[RS2_MSB:RS2_LSB];
	assign dec_imm    = instr[IMM_MSB:IMM_LSB];

	// SW and BR read their second source through the rd field
	assign rd2_idx  = (ctl_mem_write || ctl_branch) ? dec_rd : dec_rs2;
	assign uses_rs2 = (ctl_reg_write && !ctl_alu_src_imm) || ctl_mem_write || ctl_branch;

	// LUI and NOP read no register
	assign uses_rs1 = (ctl_reg_write && !ctl_load_imm) || ctl_mem_write || ctl_branch;
	assign haz_rs1  = uses_rs1 ? dec_rs1 : '0;

	cpu_control control_i (
		.opcode(dec_opcode), .reg_write(ctl_reg_write), .mem_read(ctl_mem_read),
		.mem_write(ctl_mem_write), .mem_to_reg(ctl_mem_to_reg),
		.alu_src_imm(ctl_alu_src_imm), .load_imm(ctl_load_imm), .branch(ctl_branch),
		.br_cond(ctl_br_cond), .alu_op(ctl_alu_op)
	);

	reg_file reg_file_i (
		.clk(clk), .rst_n(rst_n), .rs1_idx(dec_rs1), .rs2_idx(rd2_idx),
		.we(wb_en), .wr_idx(wb_reg), .wr_data(wb_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	hazard_detector hazard_i (
		.clk(clk), .rst_n(rst_n), .ex_mem_read(ex_mem_read), .ex_wb_deferred(wb_deferred),
		.ex_dest(ex_dest), .rs1_idx(haz_rs1), .rs2_idx(rd2_idx), .uses_rs2(uses_rs2),
		.branch_taken(branch_taken), .data_hazard(data_hazard), .pc_hazard(pc_hazard),
		.stall(stall)
	);

	idex_reg idex_i (
		.clk(clk), .rst_n(rst_n), .data_hazard(data_hazard), .pc_hazard(pc_hazard),
		.reg_write_in(ctl_reg_write), .mem_read_in(ctl_mem_read),
		.mem_write_in(ctl_mem_write), .mem_to_reg_in(ctl_mem_to_reg),
		.alu_src_imm_in(ctl_alu_src_imm), .load_imm_in(ctl_load_imm),
		.branch_in(ctl_branch), .br_cond_in(ctl_br_cond), .alu_op_in(ctl_alu_op),
		.dest_in(dec_rd), .imm_in(dec_imm), .op_a_in(rs1_data), .op_b_in(rs2_data),
		.pc_in(pc), .store_data_in(rs2_data),
		.reg_write_out(ex_reg_write), .mem_read_out(ex_mem_read),
		.mem_write_out(ex_mem_write), .mem_to_reg_out(ex_mem_to_reg),
		.alu_src_imm_out(ex_alu_src_imm), .load_imm_out(ex_load_imm),
		.branch_out(ex_branch), .br_cond_out(ex_br_cond), .alu_op_out(ex_alu_op),
		.dest_out(ex_dest), .imm_out(ex_imm), .op_a_out(ex_op_a), .op_b_out(ex_op_b),
		.pc_out(ex_pc), .store_data_out(ex_store_data)
	);

	ex_stage ex_i (
		.clk(clk), .rst_n(rst_n), .ex_reg_write(ex_reg_write), .ex_mem_read(ex_mem_read),
		.ex_mem_write(ex_mem_write), .ex_mem_to_reg(ex_mem_to_reg),
		.ex_alu_src_imm(ex_alu_src_imm), .ex_load_imm(ex_load_imm),
		.ex_branch(ex_branch), .ex_br_cond(ex_br_cond), .ex_alu_op(ex_alu_op),
		.ex_dest(ex_dest), .ex_imm(ex_imm), .ex_op_a(ex_op_a), .ex_op_b(ex_op_b),
		.ex_pc(ex_pc), .ex_store_data(ex_store_data), .mem_rdata(mem_rdata),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .wb_en(wb_en), .wb_reg(wb_reg), .wb_data(wb_data),
		.wb_deferred(wb_deferred)
	);

endmodule

// File: hw/ex_stage.sv
module ex_stage
	import isa_pkg::*, pipe_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        ex_reg_write,
	input  logic        ex_mem_read,
	input  logic        ex_mem_write,
	input  logic        ex_mem_to_reg,
	input  logic        ex_alu_src_imm,
	input  logic        ex_load_imm,
	input  logic        ex_branch,
	input  br_cond_t    ex_br_cond,
	input  alu_op_t     ex_alu_op,
	input  reg_idx_t    ex_dest,
	input  logic [15:0] ex_imm,
	input  word_t       ex_op_a,
	input  word_t       ex_op_b,
	input  word_t       ex_pc,
	input  word_t       ex_store_data,
	input  word_t       mem_rdata,
	output logic        branch_taken,
	output word_t       branch_target,
	output logic        mem_read,
	output logic        mem_write,
	output word_t       mem_addr,
	output word_t       mem_wdata,
	output logic        wb_en,
	output reg_idx_t    wb_reg,
	output word_t       wb_data,
	output logic        wb_deferred
);

	word_t    imm_sext;
	word_t    alu_b;
	word_t    alu_res;
	logic     cond_true;
	logic     cur_load;
	logic     cur_alu_we;
	logic     pend_valid;
	logic     pend_load;
	reg_idx_t pend_reg;
	word_t    pend_data;

	assign imm_sext = {{16{ex_imm[15]}}, ex_imm};

	always_comb begin
		if (ex_load_imm) begin
			alu_b = {ex_imm, 16'h0000};
		end else if (ex_alu_src_imm) begin
			alu_b = imm_sext;
		end else begin
			alu_b = ex_op_b;
		end
	end

	always_comb begin
		case (ex_alu_op)
			ALU_SUB:    alu_res = ex_op_a - alu_b;
			ALU_AND:    alu_res = ex_op_a & alu_b;
			ALU_OR:     alu_res = ex_op_a | alu_b;
			ALU_XOR:    alu_res = ex_op_a ^ alu_b;
			ALU_SLT:    alu_res = {31'b0, $signed(ex_op_a) < $signed(alu_b)};
			ALU_PASS_B: alu_res = alu_b;
			default:    alu_res = ex_op_a + alu_b;
		endcase
	end

	// BR compares rs1 against the register named in the rd field
	always_comb begin
		case (ex_br_cond)
			BR_EQ:   cond_true = (ex_op_a == ex_op_b);
			BR_NE:   cond_true = (ex_op_a != ex_op_b);
			BR_LT:   cond_true = ($signed(ex_op_a) < $signed(ex_op_b));
			default: cond_true = 1'b1;
		endcase
	end

	assign branch_taken  = ex_branch && cond_true;
	assign branch_target = ex_pc + (imm_sext << 2);

	assign mem_read  = ex_mem_read;
	assign mem_write = ex_mem_write;
	assign mem_addr  = alu_res;
	assign mem_wdata = ex_store_data;

	assign cur_load    = ex_reg_write && ex_mem_to_reg;
	assign cur_alu_we  = ex_reg_write && !ex_mem_to_reg;
	assign wb_deferred = pend_valid && cur_alu_we;

	// Held write always goes first and the current ALU result takes its place
	always_comb begin
		if (pend_valid) begin
			wb_en   = 1'b1;
			wb_reg  = pend_reg;
			wb_data = pend_load ? mem_rdata : pend_data;
		end else begin
			wb_en   = cur_alu_we;
			wb_reg  = ex_dest;
			wb_data = alu_res;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend_valid <= 1'b0;
			pend_load  <= 1'b0;
		end else begin
			pend_valid <= cur_load || wb_deferred;
			pend_load  <= cur_load;
		end
	end

	always_ff @(posedge clk) begin
		pend_reg  <= ex_dest;
		pend_data <= alu_res;
	end

	// Load data reaches the write port exactly one cycle after the read strobe
	assert property (@(posedge clk) disable iff (!rst_n)
		ex_mem_read |=> (wb_en && (wb_reg == $past(ex_dest))))
		else $error("ex_stage: load write-back out of slot");

endmodule

// File: hw/hazard_detector.sv
module hazard_detector
	import pipe_ctrl_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ex_mem_read,
	input  logic     ex_wb_deferred,
	input  reg_idx_t ex_dest,
	input  reg_idx_t rs1_idx,
	input  reg_idx_t rs2_idx,
	input  logic     uses_rs2,
	input  logic     branch_taken,
	output logic     data_hazard,
	output logic     pc_hazard,
	output logic     stall
);

	logic ex_writes_late;
	logic src_match;

	// A load, or an ALU op pushed back behind a load, lands one cycle late
	assign ex_writes_late = (ex_mem_read || ex_wb_deferred) && (ex_dest != '0);

	assign src_match = (rs1_idx == ex_dest) || (uses_rs2 && (rs2_idx == ex_dest));

	assign data_hazard = ex_writes_late && src_match;
	assign pc_hazard   = branch_taken;
	assign stall       = data_hazard;

	// The bubble behind a stall never writes, so the stall clears itself
	assert property (@(posedge clk) disable iff (!rst_n) data_hazard |=> !data_hazard)
		else $error("hazard_detector: stall held for more than one cycle");

endmodule

// File: hw/idex_reg.sv
module idex_reg
	import isa_pkg::*, pipe_ctrl_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        data_hazard,
	input  logic        pc_hazard,
	input  logic        reg_write_in,
	input  logic        mem_read_in,
	input  logic        mem_write_in,
	input  logic        mem_to_reg_in,
	input  logic        alu_src_imm_in,
	input  logic        load_imm_in,
	input  logic        branch_in,
	input  br_cond_t    br_cond_in,
	input  alu_op_t     alu_op_in,
	input  reg_idx_t    dest_in,
	input  logic [15:0] imm_in,
	input  word_t       op_a_in,
	input  word_t       op_b_in,
	input  word_t       pc_in,
	input  word_t       store_data_in,
	output logic        reg_write_out,
	output logic        mem_read_out,
	output logic        mem_write_out,
	output logic        mem_to_reg_out,
	output logic        alu_src_imm_out,
	output logic        load_imm_out,
	output logic        branch_out,
	output br_cond_t    br_cond_out,
	output alu_op_t     alu_op_out,
	output reg_idx_t    dest_out,
	output logic [15:0] imm_out,
	output word_t       op_a_out,
	output word_t       op_b_out,
	output word_t       pc_out,
	output word_t       store_data_out
);

	logic bubble;

	assign bubble = data_hazard || pc_hazard;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			reg_write_out   <= 1'b0;
			mem_read_out    <= 1'b0;
			mem_write_out   <= 1'b0;
			mem_to_reg_out  <= 1'b0;
			alu_src_imm_out <= 1'b0;
			load_imm_out    <= 1'b0;
			branch_out      <= 1'b0;
			br_cond_out     <= BR_EQ;
			alu_op_out      <= ALU_ADD;
		end else begin
			// Side-effect bits dropped to turn the slot into a bubble
			reg_write_out   <= reg_write_in && !bubble;
			mem_read_out    <= mem_read_in && !bubble;
			mem_write_out   <= mem_write_in && !bubble;
			mem_to_reg_out  <= mem_to_reg_in && !bubble;
			load_imm_out    <= load_imm_in && !bubble;
			branch_out      <= branch_in && !bubble;
			alu_src_imm_out <= alu_src_imm_in;
			br_cond_out     <= br_cond_in;
			alu_op_out      <= alu_op_in;
		end
	end

	always_ff @(posedge clk) begin
		dest_out       <= pc_hazard ? '0 : dest_in;
		imm_out        <= imm_in;
		op_a_out       <= op_a_in;
		op_b_out       <= op_b_in;
		pc_out         <= pc_in;
		store_data_out <= store_data_in;
	end

	// Wrong-path instruction must not reach the register file or memory
	assert property (@(posedge clk) disable iff (!rst_n)
		pc_hazard |=> !(reg_write_out || mem_write_out || mem_read_out))
		else $error("idex_reg: squashed instruction still enabled");

endmodule
